// ==== soc_periph_pkg.sv ====
// APB widths and types, peripheral address map, register word offsets and reset values
package soc_periph_pkg;

    // Bus and pin widths
    localparam int unsigned APB_ADDR_W = 32;
    localparam int unsigned APB_DATA_W = 32;
    localparam int unsigned NGPIO      = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [NGPIO-1:0]      gpio_vec_t;

    // Region field picks one peer in a 4 kB window
    localparam int unsigned REGION_LSB = 12;
    localparam int unsigned REGION_W   = 4;
    typedef logic [REGION_W-1:0] region_t;

    localparam region_t REGION_SOC_CTRL = 4'd0;
    localparam region_t REGION_GPIO     = 4'd1;
    localparam region_t REGION_TIMER    = 4'd2;

    // Word offset inside a region
    localparam int unsigned OFFSET_LSB = 2;
    localparam int unsigned OFFSET_W   = 6;
    typedef logic [OFFSET_W-1:0] word_off_t;

    localparam word_off_t CTRL_BOOTADDR  = 6'd0;
    localparam word_off_t CTRL_FETCHEN   = 6'd1;

    localparam word_off_t GPIO_DIR       = 6'd0;
    localparam word_off_t GPIO_IN        = 6'd1;
    localparam word_off_t GPIO_OUT       = 6'd2;
    localparam word_off_t GPIO_INTEN     = 6'd3;
    localparam word_off_t GPIO_INTSTATUS = 6'd4;

    localparam word_off_t TIMER_CFG      = 6'd0;
    localparam word_off_t TIMER_COUNT    = 6'd1;
    localparam word_off_t TIMER_CMP      = 6'd2;

    localparam apb_data_t BOOTADDR_RESET  = 32'h1A00_0080;
    localparam apb_data_t TIMER_CMP_RESET = 32'hFFFF_FFFF;

endpackage

// ==== soc_event_pkg.sv ====
// Fabric controller event vector type and fixed event bit positions
package soc_event_pkg;

    localparam int unsigned FC_EVT_W = 32;

    typedef logic [FC_EVT_W-1:0] fc_event_vec_t;

    // Compare match pulse of the timer
    localparam int unsigned EVT_TIMER    = 10;

    // One pulse per rising edge of the slow reference clock
    localparam int unsigned EVT_REF_EDGE = 14;

    // Level while any GPIO status bit is pending
    localparam int unsigned EVT_GPIO     = 15;

endpackage

// ==== periph_bus_decode.sv ====
// APB region decoder with peer selects, read data mux and unmapped error response
`timescale 1ns/10ps

module periph_bus_decode (
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  soc_periph_pkg::apb_data_t rdata_ctrl_i,
    input  soc_periph_pkg::apb_data_t rdata_gpio_i,
    input  soc_periph_pkg::apb_data_t rdata_timer_i,
    output logic                      sel_ctrl_o,
    output logic                      sel_gpio_o,
    output logic                      sel_timer_o,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o
);
    import soc_periph_pkg::*;

    region_t region;
    logic    mapped;
    logic    access;

    assign region = paddr_i[REGION_LSB +: REGION_W];
    assign access = psel_i & penable_i;

    // One-hot selects, only while the master addresses us
    assign sel_ctrl_o  = psel_i & (region == REGION_SOC_CTRL);
    assign sel_gpio_o  = psel_i & (region == REGION_GPIO);
    assign sel_timer_o = psel_i & (region == REGION_TIMER);

    assign mapped = (region == REGION_SOC_CTRL) |
                    (region == REGION_GPIO) |
                    (region == REGION_TIMER);

    // Peers answer in one cycle so every access phase completes
    assign pready_o  = access;
    assign pslverr_o = access & ~mapped;

    // Read data back from the addressed peer
    always_comb begin
        case (region)
            REGION_SOC_CTRL: prdata_o = rdata_ctrl_i;
            REGION_GPIO:     prdata_o = rdata_gpio_i;
            REGION_TIMER:    prdata_o = rdata_timer_i;
            default:         prdata_o = '0;
        endcase
    end

endmodule

// ==== soc_ctrl_regs.sv ====
// SoC control register block with boot address and fetch enable
`timescale 1ns/10ps

module soc_ctrl_regs (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      sel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::apb_data_t rdata_o,
    output soc_periph_pkg::apb_data_t boot_addr_o,
    output logic                      fetch_en_o
);
    import soc_periph_pkg::*;

    word_off_t offset;
    logic      wr_en;
    apb_data_t boot_addr_q;
    logic      fetch_en_q;

    assign offset = paddr_i[OFFSET_LSB +: OFFSET_W];
    assign wr_en  = sel_i & penable_i & pwrite_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            boot_addr_q <= BOOTADDR_RESET;
            fetch_en_q  <= 1'b0;
        end else if (wr_en) begin
            case (offset)
                CTRL_BOOTADDR: boot_addr_q <= pwdata_i;
                // Only bit 0 is kept
                CTRL_FETCHEN:  fetch_en_q  <= pwdata_i[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (offset)
            CTRL_BOOTADDR: rdata_o = boot_addr_q;
            CTRL_FETCHEN:  rdata_o = {{(APB_DATA_W-1){1'b0}}, fetch_en_q};
            default:       rdata_o = '0;
        endcase
    end

    assign boot_addr_o = boot_addr_q;
    assign fetch_en_o  = fetch_en_q;

endmodule

// ==== gpio_regs.sv ====
// GPIO register block with input synchronizer, rising-edge interrupts and clear-on-read status
`timescale 1ns/10ps

module gpio_regs (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      sel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    input  soc_periph_pkg::gpio_vec_t gpio_in_i,
    output soc_periph_pkg::apb_data_t rdata_o,
    output soc_periph_pkg::gpio_vec_t gpio_out_o,
    output soc_periph_pkg::gpio_vec_t gpio_dir_o,
    output logic                      irq_o
);
    import soc_periph_pkg::*;

    word_off_t offset;
    logic      wr_en;
    logic      rd_status;
    gpio_vec_t sync_q1;
    gpio_vec_t sync_q2;
    gpio_vec_t prev_q;
    gpio_vec_t rise;
    gpio_vec_t dir_q;
    gpio_vec_t out_q;
    gpio_vec_t inten_q;
    gpio_vec_t status_q;

    assign offset    = paddr_i[OFFSET_LSB +: OFFSET_W];
    assign wr_en     = sel_i & penable_i & pwrite_i;
    assign rd_status = sel_i & penable_i & ~pwrite_i & (offset == GPIO_INTSTATUS);

    // Two flops of synchronizer, then one more to see the previous value
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end else begin
            sync_q1 <= gpio_in_i;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    // Enabled rising edges on the synchronized pins
    assign rise = sync_q2 & ~prev_q & inten_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dir_q   <= '0;
            out_q   <= '0;
            inten_q <= '0;
        end else if (wr_en) begin
            case (offset)
                GPIO_DIR:   dir_q   <= pwdata_i[NGPIO-1:0];
                GPIO_OUT:   out_q   <= pwdata_i[NGPIO-1:0];
                GPIO_INTEN: inten_q <= pwdata_i[NGPIO-1:0];
                default: ;
            endcase
        end
    end

    // A read returns the pending bits and drops them
    // New edges in the same cycle stay pending
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_q <= '0;
        end else if (rd_status) begin
            status_q <= rise;
        end else begin
            status_q <= status_q | rise;
        end
    end

    always_comb begin
        case (offset)
            GPIO_DIR:       rdata_o = apb_data_t'(dir_q);
            GPIO_IN:        rdata_o = apb_data_t'(sync_q2);
            GPIO_OUT:       rdata_o = apb_data_t'(out_q);
            GPIO_INTEN:     rdata_o = apb_data_t'(inten_q);
            GPIO_INTSTATUS: rdata_o = apb_data_t'(status_q);
            default:        rdata_o = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign irq_o      = |status_q;

endmodule

// ==== soc_timer.sv ====
// Timer block with reference-edge detector, tick select, counter, compare and interrupt pulse
`timescale 1ns/10ps

module soc_timer (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      sel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    input  logic                      ref_clk_i,
    output soc_periph_pkg::apb_data_t rdata_o,
    output logic                      irq_o,
    output logic                      ref_edge_o
);
    import soc_periph_pkg::*;

    word_off_t offset;
    logic      wr_en;
    logic      ref_q1;
    logic      ref_q2;
    logic      ref_q3;
    logic      ref_edge_q;
    logic [1:0] cfg_q;
    apb_data_t count_q;
    apb_data_t cmp_q;
    logic      tick;
    logic      irq_q;

    assign offset = paddr_i[OFFSET_LSB +: OFFSET_W];
    assign wr_en  = sel_i & penable_i & pwrite_i;

    ////////////////////////////////////////
    // Reference clock edge detect
    ////////////////////////////////////////

    // Pulse comes out 3 cycles after the slow edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ref_q1     <= 1'b0;
            ref_q2     <= 1'b0;
            ref_q3     <= 1'b0;
            ref_edge_q <= 1'b0;
        end else begin
            ref_q1     <= ref_clk_i;
            ref_q2     <= ref_q1;
            ref_q3     <= ref_q2;
            ref_edge_q <= ref_q2 & ~ref_q3;
        end
    end

    ////////////////////////////////////////
    // Registers and counter
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q <= 2'b00;
            cmp_q <= TIMER_CMP_RESET;
        end else if (wr_en) begin
            case (offset)
                TIMER_CFG: cfg_q <= pwdata_i[1:0];
                TIMER_CMP: cmp_q <= pwdata_i;
                default: ;
            endcase
        end
    end

    // Bit 0 enables, bit 1 counts reference edges instead of cycles
    assign tick = cfg_q[0] & (cfg_q[1] ? ref_edge_q : 1'b1);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            irq_q   <= 1'b0;
        end else begin
            irq_q <= 1'b0;
            if (wr_en && offset == TIMER_COUNT) begin
                count_q <= pwdata_i;
            end else if (tick) begin
                if (count_q == cmp_q) begin
                    count_q <= '0;
                    irq_q   <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (offset)
            TIMER_CFG:   rdata_o = {{(APB_DATA_W-2){1'b0}}, cfg_q};
            TIMER_COUNT: rdata_o = count_q;
            TIMER_CMP:   rdata_o = cmp_q;
            default:     rdata_o = '0;
        endcase
    end

    assign irq_o      = irq_q;
    assign ref_edge_o = ref_edge_q;

endmodule

// ==== soc_peripherals.sv ====
// Peripheral subsystem top with APB decoder, control, GPIO and timer blocks and the event vector
`timescale 1ns/10ps

module soc_peripherals (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         slow_clk_i,
    // APB slave port
    input  soc_periph_pkg::apb_addr_t    paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  soc_periph_pkg::apb_data_t    pwdata_i,
    output soc_periph_pkg::apb_data_t    prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    // Core boot control
    output soc_periph_pkg::apb_data_t    boot_addr_o,
    output logic                         fetch_en_o,
    // GPIO pins
    input  soc_periph_pkg::gpio_vec_t    gpio_in_i,
    output soc_periph_pkg::gpio_vec_t    gpio_out_o,
    output soc_periph_pkg::gpio_vec_t    gpio_dir_o,
    output soc_event_pkg::fc_event_vec_t fc_events_o
);
    import soc_periph_pkg::*;
    import soc_event_pkg::*;

    logic      sel_ctrl;
    logic      sel_gpio;
    logic      sel_timer;
    apb_data_t rdata_ctrl;
    apb_data_t rdata_gpio;
    apb_data_t rdata_timer;
    logic      gpio_irq;
    logic      timer_irq;
    logic      ref_edge;

    ////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////

    periph_bus_decode i_bus_decode (
        .paddr_i       ( paddr_i     ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .rdata_ctrl_i  ( rdata_ctrl  ),
        .rdata_gpio_i  ( rdata_gpio  ),
        .rdata_timer_i ( rdata_timer ),
        .sel_ctrl_o    ( sel_ctrl    ),
        .sel_gpio_o    ( sel_gpio    ),
        .sel_timer_o   ( sel_timer   ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    ////////////////////////////////////////
    // Register blocks
    ////////////////////////////////////////

    soc_ctrl_regs i_soc_ctrl (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .sel_i       ( sel_ctrl    ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .rdata_o     ( rdata_ctrl  ),
        .boot_addr_o ( boot_addr_o ),
        .fetch_en_o  ( fetch_en_o  )
    );

    gpio_regs i_gpio (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .sel_i      ( sel_gpio   ),
        .penable_i  ( penable_i  ),
        .pwrite_i   ( pwrite_i   ),
        .paddr_i    ( paddr_i    ),
        .pwdata_i   ( pwdata_i   ),
        .gpio_in_i  ( gpio_in_i  ),
        .rdata_o    ( rdata_gpio ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .irq_o      ( gpio_irq   )
    );

    soc_timer i_timer (
        .clk_i      ( clk_i       ),
        .arst_n_i   ( arst_n_i    ),
        .sel_i      ( sel_timer   ),
        .penable_i  ( penable_i   ),
        .pwrite_i   ( pwrite_i    ),
        .paddr_i    ( paddr_i     ),
        .pwdata_i   ( pwdata_i    ),
        .ref_clk_i  ( slow_clk_i  ),
        .rdata_o    ( rdata_timer ),
        .irq_o      ( timer_irq   ),
        .ref_edge_o ( ref_edge    )
    );

    // Unused event positions stay zero
    always_comb begin
        fc_events_o               = '0;
        fc_events_o[EVT_TIMER]    = timer_irq;
        fc_events_o[EVT_REF_EDGE] = ref_edge;
        fc_events_o[EVT_GPIO]     = gpio_irq;
    end

endmodule

// ==== tb_soc_peripherals.sv ====
// Testbench for the peripheral subsystem with APB tasks, LFSR stimulus and assertion checks
`timescale 1ns/10ps

module tb_soc_peripherals;
    import soc_periph_pkg::*;
    import soc_event_pkg::*;

    localparam int      APB_TIMEOUT     = 16;
    localparam int      EVENT_TIMEOUT   = 400;
    localparam region_t REGION_UNMAPPED = 4'd5;

    logic          clk_i;
    logic          slow_clk_i;
    logic          arst_n_i;
    apb_addr_t     paddr_i;
    logic          psel_i;
    logic          penable_i;
    logic          pwrite_i;
    apb_data_t     pwdata_i;
    apb_data_t     prdata_o;
    logic          pready_o;
    logic          pslverr_o;
    apb_data_t     boot_addr_o;
    logic          fetch_en_o;
    gpio_vec_t     gpio_in_i;
    gpio_vec_t     gpio_out_o;
    gpio_vec_t     gpio_dir_o;
    fc_event_vec_t fc_events_o;

    logic [31:0] lfsr_q;
    logic        last_slverr;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    soc_peripherals DUT (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .slow_clk_i  ( slow_clk_i  ),
        .paddr_i     ( paddr_i     ),
        .psel_i      ( psel_i      ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .pwdata_i    ( pwdata_i    ),
        .prdata_o    ( prdata_o    ),
        .pready_o    ( pready_o    ),
        .pslverr_o   ( pslverr_o   ),
        .boot_addr_o ( boot_addr_o ),
        .fetch_en_o  ( fetch_en_o  ),
        .gpio_in_i   ( gpio_in_i   ),
        .gpio_out_o  ( gpio_out_o  ),
        .gpio_dir_o  ( gpio_dir_o  ),
        .fc_events_o ( fc_events_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Slow reference clock, 80 ns period
    initial begin
        slow_clk_i = 1'b0;
        forever #40 slow_clk_i = ~slow_clk_i;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            value  = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic apb_addr_t reg_addr(input region_t region, input word_off_t off);
        apb_addr_t addr;
        addr = '0;
        addr[REGION_LSB +: REGION_W] = region;
        addr[OFFSET_LSB +: OFFSET_W] = off;
        return addr;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Setup phase, then access phase until pready_o, sampled mid-cycle
    task automatic apb_access(input logic write, input apb_addr_t addr,
                              input apb_data_t wdata, output apb_data_t rdata);
        int waited;
        waited = 0;
        @(negedge clk_i);
        paddr_i   = addr;
        pwrite_i  = write;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;
        while (!pready_o && waited < APB_TIMEOUT) begin
            @(negedge clk_i);
            #1;
            waited++;
        end
        if (!pready_o) begin
            $display("APB transfer to %h did not complete within %0d cycles", addr, APB_TIMEOUT);
            errors++;
        end
        rdata       = prdata_o;
        last_slverr = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        apb_access(1'b0, addr, '0, data);
    endtask

    // Returns at the falling edge where the event bit is seen high
    task automatic wait_event(input int pos, output int cycles);
        cycles = 0;
        @(negedge clk_i);
        while (!fc_events_o[pos] && cycles < EVENT_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!fc_events_o[pos]) begin
            $display("Event bit %0d never went high within %0d cycles", pos, EVENT_TIMEOUT);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int        start;
        int        cycles;
        int        ref_count;
        apb_data_t rd;
        apb_data_t boot_val;
        apb_data_t fetch_val;
        apb_data_t out_val;
        apb_data_t dir_val;
        apb_data_t in_val;
        apb_data_t en_mask;
        apb_data_t cmp;

        lfsr_q       = 32'd43;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_slverr  = 1'b0;
        arst_n_i     = 1'b0;
        paddr_i      = '0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        pwdata_i     = '0;
        gpio_in_i    = '0;

        // Reset values are checked at the end of the reset window
        start = errors;
        repeat (8) @(negedge clk_i);
        expect_equal("boot_addr_o", boot_addr_o, BOOTADDR_RESET);
        expect_equal("fetch_en_o", 32'(fetch_en_o), 32'h0);
        expect_equal("gpio_out_o", gpio_out_o, 32'h0);
        expect_equal("gpio_dir_o", gpio_dir_o, 32'h0);
        expect_equal("fc_events_o", fc_events_o, 32'h0);
        expect_equal("pslverr_o", 32'(pslverr_o), 32'h0);
        arst_n_i = 1'b1;
        apb_read(reg_addr(REGION_GPIO, GPIO_DIR), rd);
        expect_equal("GPIO_DIR", rd, 32'h0);
        expect_equal("pslverr_o", 32'(last_slverr), 32'h0);
        report_test("reset state", start);

        // Bit 0 set so fetch enable leaves its reset value
        start     = errors;
        boot_val  = next_random(32);
        fetch_val = next_random(32) | 32'h1;
        apb_write(reg_addr(REGION_SOC_CTRL, CTRL_BOOTADDR), boot_val);
        expect_equal("boot_addr_o", boot_addr_o, boot_val);
        apb_read(reg_addr(REGION_SOC_CTRL, CTRL_BOOTADDR), rd);
        expect_equal("CTRL_BOOTADDR", rd, boot_val);
        apb_write(reg_addr(REGION_SOC_CTRL, CTRL_FETCHEN), fetch_val);
        expect_equal("fetch_en_o", 32'(fetch_en_o), {31'h0, fetch_val[0]});
        apb_read(reg_addr(REGION_SOC_CTRL, CTRL_FETCHEN), rd);
        expect_equal("CTRL_FETCHEN", rd, {31'h0, fetch_val[0]});
        report_test("soc control access", start);

        start   = errors;
        out_val = next_random(32);
        dir_val = next_random(32);
        in_val  = next_random(32);
        apb_write(reg_addr(REGION_GPIO, GPIO_OUT), out_val);
        apb_write(reg_addr(REGION_GPIO, GPIO_DIR), dir_val);
        expect_equal("gpio_out_o", gpio_out_o, out_val);
        expect_equal("gpio_dir_o", gpio_dir_o, dir_val);
        apb_read(reg_addr(REGION_GPIO, GPIO_OUT), rd);
        expect_equal("GPIO_OUT", rd, out_val);
        apb_read(reg_addr(REGION_GPIO, GPIO_DIR), rd);
        expect_equal("GPIO_DIR", rd, dir_val);
        gpio_in_i = in_val;
        // Two synchronizer stages
        repeat (2) @(negedge clk_i);
        apb_read(reg_addr(REGION_GPIO, GPIO_IN), rd);
        expect_equal("GPIO_IN", rd, in_val);
        report_test("gpio output and input", start);

        // Bit 31 rises too but stays disabled
        start     = errors;
        gpio_in_i = '0;
        repeat (3) @(negedge clk_i);
        en_mask     = next_random(32) | 32'h1;
        en_mask[31] = 1'b0;
        apb_write(reg_addr(REGION_GPIO, GPIO_INTEN), en_mask);
        gpio_in_i = en_mask | 32'h8000_0000;
        wait_event(EVT_GPIO, cycles);
        apb_read(reg_addr(REGION_GPIO, GPIO_INTSTATUS), rd);
        expect_equal("GPIO_INTSTATUS", rd, en_mask);
        apb_read(reg_addr(REGION_GPIO, GPIO_INTSTATUS), rd);
        expect_equal("GPIO_INTSTATUS", rd, 32'h0);
        expect_equal("fc_events_o[EVT_GPIO]", 32'(fc_events_o[EVT_GPIO]), 32'h0);
        report_test("gpio interrupt", start);

        // Cycle ticks give a pulse every cmp+1 cycles
        start = errors;
        cmp   = 32'd2 + next_random(3);
        apb_write(reg_addr(REGION_TIMER, TIMER_CMP), cmp);
        apb_write(reg_addr(REGION_TIMER, TIMER_COUNT), 32'h0);
        apb_write(reg_addr(REGION_TIMER, TIMER_CFG), 32'h1);
        wait_event(EVT_TIMER, cycles);
        wait_event(EVT_TIMER, cycles);
        expect_equal("timer pulse spacing", 32'(cycles + 1), cmp + 32'd1);

        // Reference ticks give cmp+1 reference edges per timer pulse
        cmp = 32'd1 + next_random(2);
        apb_write(reg_addr(REGION_TIMER, TIMER_CFG), 32'h0);
        apb_write(reg_addr(REGION_TIMER, TIMER_CMP), cmp);
        apb_write(reg_addr(REGION_TIMER, TIMER_COUNT), 32'h0);
        apb_write(reg_addr(REGION_TIMER, TIMER_CFG), 32'h3);
        wait_event(EVT_TIMER, cycles);
        ref_count = 0;
        cycles    = 0;
        @(negedge clk_i);
        while (!fc_events_o[EVT_TIMER] && cycles < EVENT_TIMEOUT) begin
            if (fc_events_o[EVT_REF_EDGE]) begin
                ref_count++;
            end
            @(negedge clk_i);
            cycles++;
        end
        if (!fc_events_o[EVT_TIMER]) begin
            $display("Second timer pulse in reference mode never arrived");
            errors++;
        end
        expect_equal("reference edges per timer pulse", 32'(ref_count), cmp + 32'd1);
        apb_write(reg_addr(REGION_TIMER, TIMER_CFG), 32'h0);
        report_test("timer", start);

        start = errors;
        apb_read(reg_addr(REGION_UNMAPPED, 6'd0), rd);
        expect_equal("pslverr_o", 32'(last_slverr), 32'h1);
        expect_equal("prdata_o", rd, 32'h0);
        apb_write(reg_addr(REGION_UNMAPPED, 6'd0), next_random(32));
        expect_equal("pslverr_o", 32'(last_slverr), 32'h1);
        apb_read(reg_addr(REGION_SOC_CTRL, CTRL_BOOTADDR), rd);
        expect_equal("CTRL_BOOTADDR", rd, boot_val);
        expect_equal("pslverr_o", 32'(last_slverr), 32'h0);
        report_test("unmapped access", start);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
soc_periph_pkg.sv
soc_event_pkg.sv
periph_bus_decode.sv
soc_ctrl_regs.sv
gpio_regs.sv
soc_timer.sv
soc_peripherals.sv
tb_soc_peripherals.sv

// ==== Makefile ====
TOP := tb_soc_peripherals

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f --Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
		echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf obj_dir
